// File: common/priv_defines.svh
`ifndef PRIV_DEFINES_SVH
`define PRIV_DEFINES_SVH

// Data path width
`define PRIV_XLEN 32

// Returned by mhartid
`define PRIV_HART_ID 32'h0000_0000

// Machine CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_MHARTID   12'hF14

// Direct mode trap vector out of reset
`define MTVEC_RESET 32'h0000_0200

// MXL = 1, I and U extensions
`define MISA_VALUE 32'h4010_0100

`endif

// File: common/priv_pkg.sv
`default_nettype none
`include "priv_defines.svh"

package priv_pkg;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_level_t;

    typedef enum logic [1:0] {
        CSR_READ  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

    // Exception codes in priority order
    typedef enum logic [3:0] {
        INSN_MAL    = 4'd0,
        INSN_FAULT  = 4'd1,
        ILLEGAL     = 4'd2,
        BREAKPOINT  = 4'd3,
        LOAD_MAL    = 4'd4,
        LOAD_FAULT  = 4'd5,
        STORE_MAL   = 4'd6,
        STORE_FAULT = 4'd7,
        ECALL_U     = 4'd8,
        ECALL_M     = 4'd11
    } cause_t;

    // Interrupt codes reuse exception values and differ by the interrupt bit
    localparam cause_t SOFT_INT_M  = cause_t'(4'd3);
    localparam cause_t TIMER_INT_M = cause_t'(4'd7);
    localparam cause_t EXT_INT_M   = cause_t'(4'd11);

    typedef struct packed {
        logic                  csr_valid;
        csr_op_t               csr_op;
        logic [11:0]           csr_addr;
        logic [`PRIV_XLEN-1:0] wdata;
        logic                  instr_ret;   // One strobe per retired instruction
        logic                  mal_insn;
        logic                  fault_insn;
        logic                  illegal_insn;
        logic                  breakpoint;
        logic                  mal_l;
        logic                  fault_l;
        logic                  mal_s;
        logic                  fault_s;
        logic                  env;         // ecall
        logic                  ret;         // mret
        logic                  wfi;
        logic [`PRIV_XLEN-1:0] epc;
        logic [`PRIV_XLEN-1:0] badaddr;
    } pipe_req_t;

    typedef struct packed {
        logic [`PRIV_XLEN-1:0] rdata;
        logic                  invalid_priv_isn;
        logic                  insert_pc;
        logic [`PRIV_XLEN-1:0] priv_pc;
        logic                  intr;
    } priv_resp_t;

    typedef struct packed {
        logic timer_int;
        logic soft_int;
        logic ext_int;
    } core_int_t;

    // Fields the trap logic needs from the CSR file
    typedef struct packed {
        logic                  mstatus_mie;
        logic                  mstatus_mpie;
        priv_level_t           mstatus_mpp;
        logic                  mstatus_tw;
        logic                  mie_msie;
        logic                  mie_mtie;
        logic                  mie_meie;
        logic                  mip_msip;
        logic                  mip_mtip;
        logic                  mip_meip;
        logic [`PRIV_XLEN-1:0] mtvec;
        logic [`PRIV_XLEN-1:0] mepc;
    } csr_state_t;

    typedef struct packed {
        logic                  take_trap;
        logic                  take_mret;
        logic                  is_int;
        cause_t                cause;
        logic [`PRIV_XLEN-1:0] epc;
        logic [`PRIV_XLEN-1:0] tval;
    } trap_upd_t;

endpackage

`default_nettype wire

// File: priv/priv_csr.sv
`timescale 1ns/100ps
`default_nettype none
`include "priv_defines.svh"

module priv_csr import priv_pkg::*; (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  pipe_req_t             req,
    input  core_int_t             ints,
    input  priv_level_t           curr_mode,
    input  trap_upd_t             upd,
    output logic [`PRIV_XLEN-1:0] rdata,
    output logic                  invalid_csr,
    output csr_state_t            state
);

    logic                  mstatus_mie;
    logic                  mstatus_mpie;
    priv_level_t           mstatus_mpp;
    logic                  mstatus_tw;      // Timeout wait traps wfi in U mode
    logic                  mie_msie;
    logic                  mie_mtie;
    logic                  mie_meie;
    logic [`PRIV_XLEN-1:0] mtvec;
    logic [`PRIV_XLEN-1:0] mscratch;
    logic [`PRIV_XLEN-1:0] mepc;
    logic                  mcause_int;
    logic [3:0]            mcause_code;
    logic [`PRIV_XLEN-1:0] mtval;
    logic [63:0]           mcycle;
    logic [63:0]           minstret;

    logic [`PRIV_XLEN-1:0] mstatus_rd;
    logic [`PRIV_XLEN-1:0] mie_rd;
    logic [`PRIV_XLEN-1:0] mip_rd;
    logic [`PRIV_XLEN-1:0] new_val;
    logic                  csr_known;
    logic                  csr_wen;

    // Packed views of the bit-field registers
    always_comb begin
        mstatus_rd         = '0;
        mstatus_rd[3]      = mstatus_mie;
        mstatus_rd[7]      = mstatus_mpie;
        mstatus_rd[12:11]  = mstatus_mpp;
        mstatus_rd[21]     = mstatus_tw;
        mie_rd             = '0;
        mie_rd[3]          = mie_msie;
        mie_rd[7]          = mie_mtie;
        mie_rd[11]         = mie_meie;
        mip_rd             = '0;
        mip_rd[3]          = ints.soft_int;   // Pending bits follow the source levels
        mip_rd[7]          = ints.timer_int;
        mip_rd[11]         = ints.ext_int;
    end

    // Address decode and read mux
    always_comb begin
        csr_known = 1'b1;
        rdata     = '0;
        case (req.csr_addr)
            `CSR_MSTATUS:   rdata = mstatus_rd;
            `CSR_MISA:      rdata = `MISA_VALUE;
            `CSR_MIE:       rdata = mie_rd;
            `CSR_MTVEC:     rdata = mtvec;
            `CSR_MSCRATCH:  rdata = mscratch;
            `CSR_MEPC:      rdata = mepc;
            `CSR_MCAUSE:    rdata = {mcause_int, {(`PRIV_XLEN-5){1'b0}}, mcause_code};
            `CSR_MTVAL:     rdata = mtval;
            `CSR_MIP:       rdata = mip_rd;
            `CSR_MCYCLE:    rdata = mcycle[31:0];
            `CSR_MCYCLEH:   rdata = mcycle[63:32];
            `CSR_MINSTRET:  rdata = minstret[31:0];
            `CSR_MINSTRETH: rdata = minstret[63:32];
            `CSR_MHARTID:   rdata = `PRIV_HART_ID;
            default:        csr_known = 1'b0;
        endcase
    end

    // Address bits [9:8] give the lowest privilege allowed to access
    assign invalid_csr = req.csr_valid & (~csr_known
                       | ((req.csr_addr[11:10] == 2'b11) & (req.csr_op != CSR_READ))
                       | ((curr_mode == U_MODE) & (req.csr_addr[9:8] == 2'b11)));

    always_comb begin
        case (req.csr_op)
            CSR_WRITE: new_val = req.wdata;
            CSR_SET:   new_val = rdata | req.wdata;
            CSR_CLEAR: new_val = rdata & ~req.wdata;
            default:   new_val = rdata;
        endcase
    end

    assign csr_wen = req.csr_valid & (req.csr_op != CSR_READ) & ~invalid_csr;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= U_MODE;
            mstatus_tw   <= 1'b0;
        end else if (upd.take_trap) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= curr_mode;     // Mode the trap came from
        end else if (upd.take_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= U_MODE;
        end else if (csr_wen && req.csr_addr == `CSR_MSTATUS) begin
            mstatus_mie  <= new_val[3];
            mstatus_mpie <= new_val[7];
            // Encodings other than M fall back to U
            mstatus_mpp  <= (new_val[12:11] == 2'b11) ? M_MODE : U_MODE;
            mstatus_tw   <= new_val[21];
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
            mtvec    <= `MTVEC_RESET;
        end else if (csr_wen && req.csr_addr == `CSR_MIE) begin
            mie_msie <= new_val[3];
            mie_mtie <= new_val[7];
            mie_meie <= new_val[11];
        end else if (csr_wen && req.csr_addr == `CSR_MTVEC) begin
            mtvec <= {new_val[`PRIV_XLEN-1:2], 2'b00};   // Direct mode only
        end
    end

    always_ff @(posedge CLK) begin
        if (csr_wen && req.csr_addr == `CSR_MSCRATCH) begin
            mscratch <= new_val;
        end
    end

    // A trap overrides a CSR write in the same cycle
    always_ff @(posedge CLK) begin
        if (upd.take_trap) begin
            mepc        <= {upd.epc[`PRIV_XLEN-1:2], 2'b00};
            mcause_int  <= upd.is_int;
            mcause_code <= upd.cause;
            mtval       <= upd.tval;
        end else if (csr_wen) begin
            if (req.csr_addr == `CSR_MEPC) begin
                mepc <= {new_val[`PRIV_XLEN-1:2], 2'b00};
            end
            if (req.csr_addr == `CSR_MCAUSE) begin
                mcause_int  <= new_val[`PRIV_XLEN-1];
                mcause_code <= new_val[3:0];
            end
            if (req.csr_addr == `CSR_MTVAL) begin
                mtval <= new_val;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else if (csr_wen && req.csr_addr == `CSR_MCYCLE) begin
            mcycle[31:0] <= new_val;
        end else if (csr_wen && req.csr_addr == `CSR_MCYCLEH) begin
            mcycle[63:32] <= new_val;
        end else begin
            mcycle <= mcycle + 64'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (csr_wen && req.csr_addr == `CSR_MINSTRET) begin
            minstret[31:0] <= new_val;
        end else if (csr_wen && req.csr_addr == `CSR_MINSTRETH) begin
            minstret[63:32] <= new_val;
        end else if (req.instr_ret) begin
            minstret <= minstret + 64'd1;
        end
    end

    always_comb begin
        state.mstatus_mie  = mstatus_mie;
        state.mstatus_mpie = mstatus_mpie;
        state.mstatus_mpp  = mstatus_mpp;
        state.mstatus_tw   = mstatus_tw;
        state.mie_msie     = mie_msie;
        state.mie_mtie     = mie_mtie;
        state.mie_meie     = mie_meie;
        state.mip_msip     = ints.soft_int;
        state.mip_mtip     = ints.timer_int;
        state.mip_meip     = ints.ext_int;
        state.mtvec        = mtvec;
        state.mepc         = mepc;
    end

endmodule

`default_nettype wire

// File: priv/priv_trap_handler.sv
`timescale 1ns/100ps
`default_nettype none
`include "priv_defines.svh"

module priv_trap_handler import priv_pkg::*; (
    input  logic        CLK,
    input  logic        rst_n,
    input  pipe_req_t   req,
    input  logic        invalid_csr,
    input  csr_state_t  state,
    output trap_upd_t   upd,
    output priv_level_t curr_mode,
    output priv_resp_t  resp_ctl
);

    logic                  ex_valid;
    cause_t                ex_cause;
    logic [2:0]            int_pend;    // ext, soft, timer
    logic                  int_en;
    logic                  int_valid;
    cause_t                int_cause;
    logic                  mret_req;
    logic                  insert_pc_q;
    logic                  intr_q;
    logic [`PRIV_XLEN-1:0] priv_pc_q;

    // Highest priority exception wins
    always_comb begin
        ex_valid = 1'b1;
        ex_cause = INSN_MAL;
        if (req.mal_insn)          ex_cause = INSN_MAL;
        else if (req.fault_insn)   ex_cause = INSN_FAULT;
        else if (req.illegal_insn) ex_cause = ILLEGAL;
        else if (req.breakpoint)   ex_cause = BREAKPOINT;
        else if (req.mal_l)        ex_cause = LOAD_MAL;
        else if (req.fault_l)      ex_cause = LOAD_FAULT;
        else if (req.mal_s)        ex_cause = STORE_MAL;
        else if (req.fault_s)      ex_cause = STORE_FAULT;
        else if (req.env)          ex_cause = (curr_mode == M_MODE) ? ECALL_M : ECALL_U;
        else                       ex_valid = 1'b0;
    end

    assign int_pend = {state.mip_meip & state.mie_meie,
                       state.mip_msip & state.mie_msie,
                       state.mip_mtip & state.mie_mtie};

    // U mode code can always be interrupted into M mode
    assign int_en    = (curr_mode == U_MODE) | state.mstatus_mie;
    assign int_valid = (|int_pend) & int_en & ~insert_pc_q;   // Hold off during a redirect

    always_comb begin
        if (int_pend[2]) begin
            int_cause = EXT_INT_M;
        end else if (int_pend[1]) begin
            int_cause = SOFT_INT_M;
        end else begin
            int_cause = TIMER_INT_M;
        end
    end

    assign mret_req = req.ret & (curr_mode == M_MODE);

    always_comb begin
        upd.take_trap = ex_valid | int_valid;
        upd.take_mret = mret_req & ~(ex_valid | int_valid);
        upd.is_int    = ~ex_valid & int_valid;
        upd.cause     = ex_valid ? ex_cause : int_cause;
        upd.epc       = req.epc;
        upd.tval      = ex_valid ? req.badaddr : '0;   // No faulting address for interrupts
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            curr_mode   <= M_MODE;
            insert_pc_q <= 1'b0;
            intr_q      <= 1'b0;
        end else begin
            insert_pc_q <= upd.take_trap | upd.take_mret;
            intr_q      <= upd.take_trap & upd.is_int;
            if (upd.take_trap) begin
                curr_mode <= M_MODE;
            end else if (upd.take_mret) begin
                curr_mode <= state.mstatus_mpp;   // Value before the mret update
            end
        end
    end

    // Redirect target
    always_ff @(posedge CLK) begin
        if (upd.take_trap) begin
            priv_pc_q <= {state.mtvec[`PRIV_XLEN-1:2], 2'b00};
        end else if (upd.take_mret) begin
            priv_pc_q <= state.mepc;
        end
    end

    always_comb begin
        resp_ctl.rdata            = '0;   // Filled at the top
        resp_ctl.invalid_priv_isn = invalid_csr
                                  | (req.ret & (curr_mode == U_MODE))
                                  | (req.wfi & (curr_mode == U_MODE) & state.mstatus_tw);
        resp_ctl.insert_pc        = insert_pc_q;
        resp_ctl.priv_pc          = priv_pc_q;
        resp_ctl.intr             = intr_q;
    end

endmodule

`default_nettype wire

// File: design/priv_block.sv
`timescale 1ns/100ps
`default_nettype none
`include "priv_defines.svh"

module priv_block import priv_pkg::*; (
    input  logic       CLK,
    input  logic       rst_n,
    input  pipe_req_t  req,
    input  core_int_t  ints,
    output priv_resp_t resp
);

    logic [`PRIV_XLEN-1:0] csr_rdata;
    logic                  invalid_csr;
    csr_state_t            csr_state;
    trap_upd_t             trap_upd;
    priv_level_t           curr_mode;
    priv_resp_t            resp_ctl;

    // Machine CSRs and counters
    priv_csr csr_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .req         (req),
        .ints        (ints),
        .curr_mode   (curr_mode),
        .upd         (trap_upd),
        .rdata       (csr_rdata),
        .invalid_csr (invalid_csr),
        .state       (csr_state)
    );

    // Mode, trap arbitration and redirect
    priv_trap_handler trap_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .req         (req),
        .invalid_csr (invalid_csr),
        .state       (csr_state),
        .upd         (trap_upd),
        .curr_mode   (curr_mode),
        .resp_ctl    (resp_ctl)
    );

    always_comb begin
        resp       = resp_ctl;
        resp.rdata = csr_rdata;   // Read data comes only from the CSR file
    end

endmodule

`default_nettype wire

// File: tests/priv_block_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "priv_defines.svh"

module priv_block_tb import priv_pkg::*; ();

    localparam int TIMEOUT = 50;   // Cycles allowed for a redirect

    logic        CLK;
    logic        rst_n;
    pipe_req_t   req;
    core_int_t   ints;
    priv_resp_t  resp;

    int          errors;
    int          checks;
    integer      seed;
    logic [31:0] mscratch_model;   // Shadow copies of the writable CSRs
    logic [31:0] mtvec_model;
    logic [31:0] rd;
    logic        inv;
    logic [31:0] count_before;
    int          pulses;

    priv_block priv_block_inst (
        .CLK   (CLK),
        .rst_n (rst_n),
        .req   (req),
        .ints  (ints),
        .resp  (resp)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        checks++;
        assert (got === expected) else begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // One CSR strobe with outputs sampled mid-cycle
    task automatic csr_access(input csr_op_t op, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic invalid);
        @(negedge CLK);
        req.csr_valid = 1'b1;
        req.csr_op    = op;
        req.csr_addr  = addr;
        req.wdata     = wdata;
        #2;
        data    = resp.rdata;
        invalid = resp.invalid_priv_isn;
        @(negedge CLK);
        req.csr_valid = 1'b0;
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] expected,
                              input string name);
        logic [31:0] data;
        logic        invalid;
        csr_access(CSR_READ, addr, 32'h0, data, invalid);
        check_val(name, data, expected);
        check_bit("invalid_priv_isn", invalid, 1'b0);
    endtask

    task automatic wait_redirect(input logic [31:0] exp_pc, input logic exp_intr);
        int n;
        n = 0;
        while (!resp.insert_pc && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (!resp.insert_pc) begin
            $display("Timed out waiting for the insert_pc redirect pulse");
            errors++;
        end else begin
            check_val("priv_pc", resp.priv_pc, exp_pc);
            check_bit("intr", resp.intr, exp_intr);
            @(negedge CLK);
            check_bit("insert_pc", resp.insert_pc, 1'b0);   // Single cycle pulse
        end
    endtask

    task automatic raise_exception(input cause_t cause, input logic [31:0] epc,
                                   input logic [31:0] badaddr);
        @(negedge CLK);
        req.epc     = epc;
        req.badaddr = badaddr;
        case (cause)
            ILLEGAL:          req.illegal_insn = 1'b1;
            ECALL_U, ECALL_M: req.env = 1'b1;
            default:          req.breakpoint = 1'b1;
        endcase
        @(negedge CLK);
        req.illegal_insn = 1'b0;
        req.env          = 1'b0;
        req.breakpoint   = 1'b0;
        wait_redirect(mtvec_model, 1'b0);
    endtask

    task automatic do_mret(input logic [31:0] exp_pc);
        @(negedge CLK);
        req.ret = 1'b1;
        @(negedge CLK);
        req.ret = 1'b0;
        wait_redirect(exp_pc, 1'b0);
    endtask

    initial begin
        int          op_sel;
        csr_op_t     op;
        logic [31:0] data;
        logic [11:0] addr;
        logic [31:0] next;
        errors = 0;
        checks = 0;
        seed   = 32'h6338;
        req    = '0;
        ints   = '0;
        rst_n  = 1'b0;
        repeat (16) @(negedge CLK);
        rst_n = 1'b1;

        read_check(`CSR_MSTATUS, 32'h0, "mstatus");
        read_check(`CSR_MTVEC, `MTVEC_RESET, "mtvec");
        read_check(`CSR_MHARTID, `PRIV_HART_ID, "mhartid");
        read_check(`CSR_MISA, `MISA_VALUE, "misa");
        check_bit("insert_pc", resp.insert_pc, 1'b0);
        check_bit("intr", resp.intr, 1'b0);

        mscratch_model = 32'h0;
        mtvec_model    = `MTVEC_RESET;
        csr_access(CSR_WRITE, `CSR_MSCRATCH, 32'h0, rd, inv);
        for (int i = 0; i < 12; i++) begin
            op_sel = {$random(seed)} % 3;
            data   = $random(seed);
            addr   = (i % 2 == 0) ? `CSR_MSCRATCH : `CSR_MTVEC;
            next   = (addr == `CSR_MSCRATCH) ? mscratch_model : mtvec_model;
            case (op_sel)
                0: begin
                    op   = CSR_WRITE;
                    next = data;
                end
                1: begin
                    op   = CSR_SET;
                    next = next | data;
                end
                default: begin
                    op   = CSR_CLEAR;
                    next = next & ~data;
                end
            endcase
            csr_access(op, addr, data, rd, inv);
            check_bit("invalid_priv_isn", inv, 1'b0);
            if (addr == `CSR_MSCRATCH) begin
                mscratch_model = next;
                read_check(addr, mscratch_model, "mscratch");
            end else begin
                mtvec_model = {next[31:2], 2'b00};   // Direct mode clears the low bits
                read_check(addr, mtvec_model, "mtvec");
            end
        end

        csr_access(CSR_WRITE, `CSR_MHARTID, 32'hffff_ffff, rd, inv);
        check_bit("invalid_priv_isn", inv, 1'b1);
        read_check(`CSR_MHARTID, `PRIV_HART_ID, "mhartid");

        // Illegal instruction taken from M mode with mie set
        csr_access(CSR_WRITE, `CSR_MSTATUS, 32'h0000_0008, rd, inv);
        raise_exception(ILLEGAL, 32'h0000_1040, 32'hdead_beef);
        read_check(`CSR_MEPC, 32'h0000_1040, "mepc");
        read_check(`CSR_MCAUSE, 32'd2, "mcause");
        read_check(`CSR_MTVAL, 32'hdead_beef, "mtval");
        read_check(`CSR_MSTATUS, 32'h0000_1880, "mstatus");

        // Set tw and mpp U before dropping to user mode
        csr_access(CSR_WRITE, `CSR_MSTATUS, 32'h0020_0080, rd, inv);
        do_mret(32'h0000_1040);
        csr_access(CSR_READ, `CSR_MSCRATCH, 32'h0, rd, inv);
        check_bit("invalid_priv_isn", inv, 1'b1);
        @(negedge CLK);
        req.ret = 1'b1;
        #2;
        check_bit("invalid_priv_isn", resp.invalid_priv_isn, 1'b1);
        @(negedge CLK);
        req.ret = 1'b0;
        req.wfi = 1'b1;
        #2;
        check_bit("invalid_priv_isn", resp.invalid_priv_isn, 1'b1);
        @(negedge CLK);
        req.wfi = 1'b0;
        raise_exception(ECALL_U, 32'h0000_2000, 32'h0);
        read_check(`CSR_MCAUSE, 32'd8, "mcause");

        csr_access(CSR_WRITE, `CSR_MIE, 32'h0000_0080, rd, inv);
        csr_access(CSR_SET, `CSR_MSTATUS, 32'h0000_0008, rd, inv);
        @(negedge CLK);
        ints.timer_int = 1'b1;
        wait_redirect(mtvec_model, 1'b1);
        read_check(`CSR_MCAUSE, 32'h8000_0007, "mcause");
        // Trap cleared mie, so the held timer level must stay pending
        read_check(`CSR_MSTATUS, 32'h0020_1880, "mstatus");
        pulses = 0;
        repeat (20) begin
            @(negedge CLK);
            if (resp.insert_pc) pulses++;
        end
        check_val("insert_pc pulses", pulses, 32'd0);
        ints.timer_int = 1'b0;

        csr_access(CSR_READ, `CSR_MINSTRET, 32'h0, count_before, inv);
        repeat (7) begin
            @(negedge CLK);
            req.instr_ret = 1'b1;
        end
        @(negedge CLK);
        req.instr_ret = 1'b0;
        read_check(`CSR_MINSTRET, count_before + 32'd7, "minstret");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/priv_pkg.sv
priv/priv_csr.sv
priv/priv_trap_handler.sv
design/priv_block.sv
tests/priv_block_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module priv_block_tb \
    -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/Vpriv_block_tb >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0
